// ==== rtl/ecg_acc_pkg.sv ====
// widths, tap/channel counts, datapath types, weight-write struct, pool phase enum
package ecg_acc_pkg;

	// ************************************************************************
	// sizes
	// ************************************************************************
	localparam int SAMPLE_W  = 8;	// ecg sample and weight width
	localparam int CONV_TAPS = 3;	// kernel length
	localparam int NUM_CH    = 8;	// output channels
	localparam int PSUM_W    = 18;	// 16b product + 2 guard bits for 3 taps

	// ************************************************************************
	// datapath types
	// ************************************************************************
	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [SAMPLE_W-1:0] weight_t;
	typedef logic signed [PSUM_W-1:0]   psum_t;
	typedef logic        [7:0]          act_t;		// unsigned, 0..127 after quant

	// index 0 holds the oldest sample
	typedef sample_t [CONV_TAPS-1:0] window_t;

	typedef weight_t [NUM_CH-1:0][CONV_TAPS-1:0] weight_bank_t;	// [ch][tap]
	typedef psum_t   [NUM_CH-1:0]                psum_vec_t;
	typedef act_t    [NUM_CH-1:0]                act_vec_t;

	// weight write port
	typedef struct packed {
		logic                         vld;	// write strobe
		logic [$clog2(NUM_CH)-1:0]    ch;	// channel index
		logic [$clog2(CONV_TAPS)-1:0] tap;	// tap index
		weight_t                      data;
	} wt_wr_t;

	// pool pair phase
	typedef enum logic {
		pool_first,		// hold incoming vector
		pool_second		// compare and emit
	} pool_phase_e;

endpackage

// ==== rtl/ecg_weight_buffer.sv ====
// weight register bank, 8 channels by 3 taps, parallel read
`timescale 1ns/1ps

module ecg_weight_buffer (
	input  logic                      clk_cal,
	input  logic                      reset,
	input  ecg_acc_pkg::wt_wr_t       wt_wr,
	output ecg_acc_pkg::weight_bank_t bank
);

	ecg_acc_pkg::weight_bank_t bank_q;

	// ************************************************************************
	// write port
	// ************************************************************************
	always_ff @(posedge clk_cal) begin
		if (reset) begin
			bank_q <= '0;				// all weights zero
		end else if (wt_wr.vld && (wt_wr.tap < ecg_acc_pkg::CONV_TAPS)) begin
			bank_q[wt_wr.ch][wt_wr.tap] <= wt_wr.data;	// single entry per write
		end
	end

	// whole bank goes out at once, pe array reads all taps every cycle
	assign bank = bank_q;

	// ************************************************************************
	// checks
	// ************************************************************************
	// tap 3 does not exist, such a write would be silently dropped
	a_tap_range : assert property (
		@(posedge clk_cal) disable iff (reset)
		wt_wr.vld |-> (wt_wr.tap < ecg_acc_pkg::CONV_TAPS)
	) else $error("weight write with tap index %0d out of range", wt_wr.tap);

endmodule

// ==== rtl/ecg_input_window.sv ====
// sliding sample window with per-frame fill counter
`timescale 1ns/1ps

module ecg_input_window (
	input  logic                 clk_cal,
	input  logic                 reset,
	input  logic                 frame_start,
	input  logic                 sample_vld,
	input  ecg_acc_pkg::sample_t sample,
	output logic                 window_vld,
	output ecg_acc_pkg::window_t window
);

	localparam int CNT_W = $clog2(ecg_acc_pkg::CONV_TAPS + 1);	// holds 0..CONV_TAPS

	logic [CNT_W-1:0] fill_cnt;	// saturating count of samples this frame

	// ************************************************************************
	// fill count and window valid
	// ************************************************************************
	always_ff @(posedge clk_cal) begin
		if (reset) begin
			fill_cnt   <= '0;
			window_vld <= 1'b0;
		end else if (frame_start) begin
			fill_cnt   <= '0;			// old samples no longer count in a new frame
			window_vld <= 1'b0;
		end else begin
			// full once 2 earlier samples + this one are in
			window_vld <= sample_vld && (fill_cnt >= CNT_W'(ecg_acc_pkg::CONV_TAPS - 1));
			if (sample_vld && (fill_cnt < CNT_W'(ecg_acc_pkg::CONV_TAPS)))
				fill_cnt <= fill_cnt + 1'b1;
		end
	end

	// newest enters at the top and the oldest drops out of index 0
	always_ff @(posedge clk_cal) begin
		if (sample_vld)
			window <= {sample, window[ecg_acc_pkg::CONV_TAPS-1:1]};
	end

	// ************************************************************************
	// checks
	// ************************************************************************
	// a sample in the frame_start cycle would be shifted in but not counted
	a_no_sample_at_start : assert property (
		@(posedge clk_cal) disable iff (reset)
		frame_start |-> !sample_vld
	) else $error("sample_vld high in the frame_start cycle");

endmodule

// ==== rtl/ecg_pe_array.sv ====
// 8-channel 3-tap multiply-accumulate array with registered partial sums
`timescale 1ns/1ps

module ecg_pe_array (
	input  logic                      clk_cal,
	input  logic                      reset,
	input  logic                      window_vld,
	input  ecg_acc_pkg::window_t      window,
	input  ecg_acc_pkg::weight_bank_t bank,
	output logic                      psum_vld,
	output ecg_acc_pkg::psum_vec_t    psum
);

	ecg_acc_pkg::psum_vec_t psum_d;		// combinational sums, one per channel

	// ************************************************************************
	// mac per channel
	// ************************************************************************
	always_comb begin
		logic signed [ecg_acc_pkg::PSUM_W-1:0]     acc;
		logic signed [2*ecg_acc_pkg::SAMPLE_W-1:0] prod;

		acc  = '0;
		prod = '0;
		for (int c = 0; c < ecg_acc_pkg::NUM_CH; c++) begin
			acc = '0;
			for (int t = 0; t < ecg_acc_pkg::CONV_TAPS; t++) begin
				prod = $signed(window[t]) * $signed(bank[c][t]);	// 8x8 signed
				acc  = acc + prod;			// sign extended to PSUM_W
			end
			psum_d[c] = acc;
		end
	end

	// ************************************************************************
	// output stage, 1 cycle after window_vld
	// ************************************************************************
	always_ff @(posedge clk_cal) begin
		if (reset)
			psum_vld <= 1'b0;
		else
			psum_vld <= window_vld;		// valid travels with the data
	end

	always_ff @(posedge clk_cal) begin
		if (window_vld)
			psum <= psum_d;			// hold last sums between windows
	end

endmodule

// ==== rtl/ecg_relu_quant.sv ====
// relu, arithmetic shift and 0..127 saturation of 8 partial sums
`timescale 1ns/1ps

module ecg_relu_quant #(
	parameter int RELU_SHIFT = 4
) (
	input  logic                   clk_cal,
	input  logic                   reset,
	input  logic                   psum_vld,
	input  ecg_acc_pkg::psum_vec_t psum,
	output logic                   act_vld,
	output ecg_acc_pkg::act_vec_t  act
);

	ecg_acc_pkg::act_vec_t act_d;

	// ************************************************************************
	// per-channel quantizer
	// ************************************************************************
	always_comb begin
		logic signed [ecg_acc_pkg::PSUM_W-1:0] shifted;

		shifted = '0;
		for (int c = 0; c < ecg_acc_pkg::NUM_CH; c++) begin
			shifted = psum[c] >>> RELU_SHIFT;	// sign kept by >>>
			if (psum[c] < 0)
				act_d[c] = 8'd0;		// relu clamp
			else if (shifted > 127)
				act_d[c] = 8'd127;		// saturate high
			else
				act_d[c] = shifted[7:0];
		end
	end

	always_ff @(posedge clk_cal) begin
		if (reset)
			act_vld <= 1'b0;
		else
			act_vld <= psum_vld;
	end

	always_ff @(posedge clk_cal) begin
		if (psum_vld)
			act <= act_d;
	end

endmodule

// ==== rtl/ecg_max_pool.sv ====
// pairwise max pooling of size 2 and stride 2 with pool phase state
`timescale 1ns/1ps

module ecg_max_pool (
	input  logic                  clk_cal,
	input  logic                  reset,
	input  logic                  frame_start,
	input  logic                  act_vld,
	input  ecg_acc_pkg::act_vec_t act,
	output logic                  pool_vld,
	output ecg_acc_pkg::act_vec_t pool_data
);

	ecg_acc_pkg::pool_phase_e phase;
	ecg_acc_pkg::act_vec_t    hold_q;	// first vector of the pair
	ecg_acc_pkg::act_vec_t    pool_max;

	// channel max of held vs incoming
	always_comb begin
		for (int c = 0; c < ecg_acc_pkg::NUM_CH; c++)
			pool_max[c] = (act[c] > hold_q[c]) ? act[c] : hold_q[c];
	end

	// ************************************************************************
	// phase FSM toggling on each act_vld
	// ************************************************************************
	always_ff @(posedge clk_cal) begin
		if (reset) begin
			phase    <= ecg_acc_pkg::pool_first;
			pool_vld <= 1'b0;
		end else if (frame_start) begin
			phase    <= ecg_acc_pkg::pool_first;	// pairing restarts with new frame
			pool_vld <= 1'b0;
		end else begin
			pool_vld <= act_vld && (phase == ecg_acc_pkg::pool_second);
			if (act_vld)
				phase <= (phase == ecg_acc_pkg::pool_first) ?
					ecg_acc_pkg::pool_second : ecg_acc_pkg::pool_first;
		end
	end

	// pair storage and pooled output
	always_ff @(posedge clk_cal) begin
		if (act_vld && (phase == ecg_acc_pkg::pool_first))
			hold_q <= act;
		if (act_vld && (phase == ecg_acc_pkg::pool_second))
			pool_data <= pool_max;		// one output per pair
	end

	// ************************************************************************
	// checks
	// ************************************************************************
	// an activation in the frame_start cycle would be dropped from the pairing
	a_idle_at_start : assert property (
		@(posedge clk_cal) disable iff (reset)
		frame_start |-> !act_vld
	) else $error("act_vld high in the frame_start cycle");

endmodule

// ==== rtl/ecg_acc_top.sv ====
// convolution engine top: weight buffer, input window, pe array, relu/quant, max pool
`timescale 1ns/1ps

module ecg_acc_top #(
	parameter int RELU_SHIFT = 4		// right shift after relu
) (
	input  logic                 clk_cal,
	input  logic                 reset,
	input  ecg_acc_pkg::wt_wr_t  wt_wr,		// weight writes, outside of frames
	input  logic                 frame_start,	// 1-cycle pulse
	input  logic                 sample_vld,
	input  ecg_acc_pkg::sample_t sample,
	output logic                 pool_vld,
	output ecg_acc_pkg::act_vec_t pool_data
);

	// ************************************************************************
	// chain links, each a valid plus payload
	// ************************************************************************
	ecg_acc_pkg::weight_bank_t bank;	// static while a frame runs

	logic                      window_vld;
	ecg_acc_pkg::window_t      window;

	logic                      psum_vld;
	ecg_acc_pkg::psum_vec_t    psum;

	logic                      act_vld;
	ecg_acc_pkg::act_vec_t     act;

	// ************************************************************************
	// instances
	// ************************************************************************
	ecg_weight_buffer u_weight_buffer (
		.clk_cal     ( clk_cal     ),
		.reset       ( reset       ),
		.wt_wr       ( wt_wr       ),
		.bank        ( bank        )
	);

	ecg_input_window u_input_window (
		.clk_cal     ( clk_cal     ),
		.reset       ( reset       ),
		.frame_start ( frame_start ),	// clears fill count
		.sample_vld  ( sample_vld  ),
		.sample      ( sample      ),
		.window_vld  ( window_vld  ),
		.window      ( window      )
	);

	ecg_pe_array u_pe_array (
		.clk_cal     ( clk_cal     ),
		.reset       ( reset       ),
		.window_vld  ( window_vld  ),
		.window      ( window      ),
		.bank        ( bank        ),
		.psum_vld    ( psum_vld    ),
		.psum        ( psum        )
	);

	ecg_relu_quant #(
		.RELU_SHIFT  ( RELU_SHIFT  )
	) u_relu_quant (
		.clk_cal     ( clk_cal     ),
		.reset       ( reset       ),
		.psum_vld    ( psum_vld    ),
		.psum        ( psum        ),
		.act_vld     ( act_vld     ),
		.act         ( act         )
	);

	ecg_max_pool u_max_pool (
		.clk_cal     ( clk_cal     ),
		.reset       ( reset       ),
		.frame_start ( frame_start ),	// back to pool_first
		.act_vld     ( act_vld     ),
		.act         ( act         ),
		.pool_vld    ( pool_vld    ),
		.pool_data   ( pool_data   )
	);

endmodule

// ==== verification/tb_ecg_acc.sv ====
// testbench: stim file loader, falling-edge drivers, pool output monitor, watchdog
`timescale 1ns/1ps

module tb_ecg_acc;

	// one stim command, W / F / S
	typedef struct packed {
		logic [7:0]           kind;	// ascii letter of the line
		logic [2:0]           ch;
		logic [1:0]           tap;
		ecg_acc_pkg::sample_t val;	// weight or sample value
	} cmd_t;

	logic                  clk_cal;
	logic                  reset;
	ecg_acc_pkg::wt_wr_t   wt_wr;
	logic                  frame_start;
	logic                  sample_vld;
	ecg_acc_pkg::sample_t  sample;
	logic                  pool_vld;
	ecg_acc_pkg::act_vec_t pool_data;

	cmd_t                  cmd_q[$];	// drive order
	ecg_acc_pkg::act_vec_t exp_q[$];	// expected pool vectors, in order
	int                    n_lines;	// lines in stim file, sizes the watchdog
	int                    n_out;		// pool outputs seen
	bit                    stim_loaded;

	// ************************************************************************
	// clock and DUT
	// ************************************************************************
	initial clk_cal = 1'b0;
	always #2 clk_cal = ~clk_cal;	// 4 ns period

	ecg_acc_top #(
		.RELU_SHIFT  ( 4           )
	) dut0 (
		.clk_cal     ( clk_cal     ),
		.reset       ( reset       ),
		.wt_wr       ( wt_wr       ),
		.frame_start ( frame_start ),
		.sample_vld  ( sample_vld  ),
		.sample      ( sample      ),
		.pool_vld    ( pool_vld    ),
		.pool_data   ( pool_data   )
	);

	// ************************************************************************
	// helpers
	// ************************************************************************
	// plain-words failure, ends the run
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// value compare, hex on mismatch
	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s = %0h, expected %0h", name, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	// parse whole file up front, E lines go straight to the expected queue
	task automatic load_stim();
		int                    fd;
		int                    n;
		int                    ch;
		int                    tap;
		int                    val;
		int                    e [8];
		string                 line;
		cmd_t                  cmd;
		ecg_acc_pkg::act_vec_t ev;

		fd = $fopen("verification/ecg_acc_stim.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the stim file verification/ecg_acc_stim.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0) begin
					n_lines++;
					cmd = '0;
					case (line.getc(0))
						"#", "\n", "\r", " ": ;	// comment or blank
						"W": begin
							n = $sscanf(line, "W %d %d %d", ch, tap, val);
							if (n != 3)
								abort_run({"malformed weight line in stim file: ", line});
							cmd.kind = "W";
							cmd.ch   = 3'(ch);
							cmd.tap  = 2'(tap);
							cmd.val  = 8'(val);
							cmd_q.push_back(cmd);
						end
						"F": begin
							cmd.kind = "F";
							cmd_q.push_back(cmd);
						end
						"S": begin
							n = $sscanf(line, "S %d", val);
							if (n != 1)
								abort_run({"malformed sample line in stim file: ", line});
							cmd.kind = "S";
							cmd.val  = 8'(val);
							cmd_q.push_back(cmd);
						end
						"E": begin
							n = $sscanf(line, "E %h %h %h %h %h %h %h %h",
								e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7]);
							if (n != 8)
								abort_run({"malformed expected line in stim file: ", line});
							for (int c = 0; c < ecg_acc_pkg::NUM_CH; c++)
								ev[c] = e[c][7:0];	// ch0 first on the line
							exp_q.push_back(ev);
						end
						default: abort_run({"unknown line in stim file: ", line});
					endcase
				end
			end
			$fclose(fd);
			stim_loaded = 1'b1;
		end
	endtask

	// all drivers start and end on a falling edge
	task automatic write_weight(input cmd_t cmd);
		wt_wr.vld  = 1'b1;
		wt_wr.ch   = cmd.ch;
		wt_wr.tap  = cmd.tap;
		wt_wr.data = cmd.val;
		@(negedge clk_cal);
		wt_wr.vld  = 1'b0;
	endtask

	task automatic start_frame();
		frame_start = 1'b1;		// single cycle pulse
		@(negedge clk_cal);
		frame_start = 1'b0;
	endtask

	task automatic send_sample(input ecg_acc_pkg::sample_t val);
		int gap;

		sample_vld = 1'b1;
		sample     = val;
		@(negedge clk_cal);
		sample_vld = 1'b0;
		gap = $urandom_range(3, 0);	// idle 0..3 cycles
		repeat (gap) @(negedge clk_cal);
	endtask

	// ************************************************************************
	// stimulus
	// ************************************************************************
	initial begin : stimulus
		cmd_t cmd;
		bit   after_sample;
		int   seed;

		reset       = 1'b1;
		wt_wr       = '0;
		frame_start = 1'b0;
		sample_vld  = 1'b0;
		sample      = '0;
		n_lines     = 0;
		n_out       = 0;
		stim_loaded = 1'b0;
		after_sample = 1'b0;
		seed = $urandom(84043);		// seeds the run once
		load_stim();
		repeat (10) @(negedge clk_cal);
		reset = 1'b0;

		foreach (cmd_q[i]) begin
			cmd = cmd_q[i];
			// let the pipeline drain before weights or a new frame
			if (after_sample && (cmd.kind != "S"))
				repeat (6) @(negedge clk_cal);
			case (cmd.kind)
				"W": write_weight(cmd);
				"F": start_frame();
				default: send_sample(cmd.val);
			endcase
			after_sample = (cmd.kind == "S");
		end

		repeat (10) @(negedge clk_cal);	// last output is 4 cycles out
		if (exp_q.size() != 0) begin
			$display("%0d expected pool outputs never arrived", exp_q.size());
			$display("** FAIL **");
			$fatal(1);
		end else begin
			$display("%0d pool outputs checked", n_out);
			$display("** PASS **");
			$finish;
		end
	end

	// ************************************************************************
	// output monitor, outputs settle before the falling edge
	// ************************************************************************
	always @(negedge clk_cal) begin : monitor
		ecg_acc_pkg::act_vec_t exp_vec;

		if (!reset && pool_vld) begin
			if (exp_q.size() == 0) begin
				abort_run("pool output arrived when none was expected");
			end else begin
				exp_vec = exp_q.pop_front();
				n_out++;
				for (int c = 0; c < ecg_acc_pkg::NUM_CH; c++)
					check_eq($sformatf("pool_data[%0d]", c), pool_data[c], exp_vec[c]);
			end
		end
	end

	// ************************************************************************
	// watchdog
	// ************************************************************************
	initial begin : watchdog
		wait (stim_loaded);
		repeat (20 * n_lines + 100) @(posedge clk_cal);	// generous per-line budget
		abort_run("timeout, the run did not finish in time");
	end

endmodule

// ==== flist.f ====
rtl/ecg_acc_pkg.sv
rtl/ecg_weight_buffer.sv
rtl/ecg_input_window.sv
rtl/ecg_pe_array.sv
rtl/ecg_relu_quant.sv
rtl/ecg_max_pool.sv
rtl/ecg_acc_top.sv
verification/tb_ecg_acc.sv

// ==== verification/ecg_acc_stim.txt ====
# W ch tap weight (decimal) | F frame start | S sample (decimal)
# E expected pool_data bytes ch0..ch7 (hex)
# ramp on ch0 and ch2, all negative ch1, full scale ch3 and ch7, others stay 0
W 0 0 1
W 0 1 2
W 0 2 3
W 1 0 -1
W 1 1 -1
W 1 2 -1
W 2 0 3
W 2 1 2
W 2 2 1
W 3 0 -127
W 3 1 -127
W 3 2 -127
W 7 0 127
W 7 1 127
W 7 2 127
# frame 1, 7 samples, 2 outputs, last window unpaired
F
S 10
S 20
S 30
S 40
S 50
S 60
S 70
E 0c 00 0a 00 00 00 00 7f
E 14 00 11 00 00 00 00 7f
# frame 2, 3 samples, one window and no output
F
S 100
S 100
S 100
# frame 3, near full scale, pairing restarts at its first window
F
S -127
S -120
S -110
S 5
S 127
S 127
E 00 16 00 7f 00 00 00 00
E 28 00 18 00 00 00 00 7f
